//--- design/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

//////////////////////////////
// Datapath widths
//////////////////////////////

// Register and ALU word width
`define DATA_W 32

// Register file address width, 32 registers
`define REG_AW 5

//////////////////////////////
// Wishbone address map
//////////////////////////////

// Word address width of the slave port
`define WB_AW 6

// Instruction register sits just above the register window
`define INSTR_ADDR 32

`endif

//--- design/mips_pkg.sv
`include "mips_defs.svh"

package mips_pkg;

  // R-type view of the instruction word
  typedef struct packed {
    logic [5:0]         op;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [`REG_AW-1:0] rd;
    logic [4:0]         shamt;
    logic [5:0]         funct;
  } r_fields_t;

  // I-type view of the instruction word
  typedef struct packed {
    logic [5:0]         op;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;
    logic [15:0]        imm;
  } i_fields_t;

  // Same 32 bits, decoded either way
  typedef union packed {
    r_fields_t rtype;
    i_fields_t itype;
  } instr_u;

  // R-type codes are funct values, I-type codes are opcodes
  typedef enum logic [5:0] {
    OP_SLL  = 6'b000000,
    OP_SRL  = 6'b000010,
    OP_SRA  = 6'b000011,
    OP_SLLV = 6'b000100,
    OP_SRLV = 6'b000110,
    OP_SRAV = 6'b000111,
    OP_ADDI = 6'b001000,
    OP_SLTI = 6'b001010,
    OP_ANDI = 6'b001100,
    OP_ORI  = 6'b001101,
    OP_XORI = 6'b001110,
    OP_LUI  = 6'b001111,
    OP_ADDU = 6'b100001,
    OP_SUBU = 6'b100011,
    OP_AND  = 6'b100100,
    OP_OR   = 6'b100101,
    OP_XOR  = 6'b100110,
    OP_NOR  = 6'b100111,
    OP_SLT  = 6'b101010
  } alu_op_e;

endpackage

//--- design/reg_port_if.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

interface reg_port_if;

  // Two read ports, addressed by control
  logic [`REG_AW-1:0] rs_addr;
  logic [`REG_AW-1:0] rt_addr;
  logic [`DATA_W-1:0] rs_data;
  logic [`DATA_W-1:0] rt_data;

  // Single write port, written on the clock edge
  logic               we;
  logic [`REG_AW-1:0] wd_addr;
  logic [`DATA_W-1:0] wd_data;

  modport ctrl (
    output rs_addr, rt_addr,
    output we, wd_addr, wd_data,
    input  rs_data, rt_data
  );

  modport regs (
    input  rs_addr, rt_addr,
    input  we, wd_addr, wd_data,
    output rs_data, rt_data
  );

endinterface

//--- design/reg_file.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module reg_file
(
  input  logic     i_clk,
  input  logic     i_rst,
  reg_port_if.regs rp
);

  localparam int NREG = 1 << `REG_AW;

  logic [`DATA_W-1:0] mem [NREG];

  //////////////////////////////
  // Write port
  //////////////////////////////

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      for (int k = 0; k < NREG; k++)
      begin
        mem[k] <= '0;
      end
    end
    else if (rp.we && (rp.wd_addr != '0))
    begin
      // Register zero is never written
      mem[rp.wd_addr] <= rp.wd_data;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // Combinational, zero register forced
  assign rp.rs_data = (rp.rs_addr == '0) ? '0 : mem[rp.rs_addr];
  assign rp.rt_data = (rp.rt_addr == '0) ? '0 : mem[rp.rt_addr];

endmodule

//--- design/operand_mux.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module operand_mux
  import mips_pkg::*;
(
  input  instr_u             i_instr,
  input  alu_op_e            i_alu_op,
  input  logic [`DATA_W-1:0] i_rs_data,
  input  logic [`DATA_W-1:0] i_rt_data,
  output logic [`DATA_W-1:0] o_opa,
  output logic [`DATA_W-1:0] o_opb,
  output logic [4:0]         o_shamt
);

  logic               r_type;
  logic               sign_ext;
  logic [`DATA_W-1:0] imm_ext;

  // Op zero selects the R-type format
  assign r_type = (i_instr.rtype.op == '0);

  // ADDI and SLTI take a signed immediate, the logic ops and LUI do not
  assign sign_ext = (i_alu_op == OP_ADDI) || (i_alu_op == OP_SLTI);

  assign imm_ext = sign_ext
                 ? {{(`DATA_W-16){i_instr.itype.imm[15]}}, i_instr.itype.imm}
                 : {{(`DATA_W-16){1'b0}}, i_instr.itype.imm};

  assign o_opa = i_rs_data;

  assign o_opb = r_type ? i_rt_data : imm_ext;

  // Only meaningful for R-type shifts
  assign o_shamt = i_instr.rtype.shamt;

endmodule

//--- design/mips_alu.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mips_alu
  import mips_pkg::*;
(
  input  logic [`DATA_W-1:0] i_opa,
  input  logic [`DATA_W-1:0] i_opb,
  input  logic [4:0]         i_shamt,
  input  alu_op_e            i_opcode,
  output logic [`DATA_W-1:0] o_result
);

  logic [4:0] var_sa;
  logic       lt_signed;

  // Variable shifts only look at the low 5 bits of B
  assign var_sa = i_opb[4:0];

  // Shared by SLT and SLTI
  assign lt_signed = $signed(i_opa) < $signed(i_opb);

  always_comb
  begin
    case (i_opcode)
      //////////////////////////////
      // R-type
      //////////////////////////////
      OP_SLL:  o_result = i_opb << i_shamt;
      OP_SRL:  o_result = i_opb >> i_shamt;
      OP_SRA:  o_result = $signed(i_opb) >>> i_shamt;
      OP_SLLV: o_result = i_opa << var_sa;
      OP_SRLV: o_result = i_opa >> var_sa;
      OP_SRAV: o_result = $signed(i_opa) >>> var_sa;
      OP_ADDU: o_result = i_opa + i_opb;
      OP_SUBU: o_result = i_opa - i_opb;
      OP_AND:  o_result = i_opa & i_opb;
      OP_OR:   o_result = i_opa | i_opb;
      OP_XOR:  o_result = i_opa ^ i_opb;
      OP_NOR:  o_result = ~(i_opa | i_opb);
      OP_SLT:  o_result = {{(`DATA_W-1){1'b0}}, lt_signed};

      //////////////////////////////
      // I-type
      //////////////////////////////
      OP_ADDI: o_result = i_opa + i_opb;
      OP_ANDI: o_result = i_opa & i_opb;
      OP_ORI:  o_result = i_opa | i_opb;
      OP_XORI: o_result = i_opa ^ i_opb;
      // Immediate moves to the upper half
      OP_LUI:  o_result = i_opb << 16;
      OP_SLTI: o_result = {{(`DATA_W-1){1'b0}}, lt_signed};

      default: o_result = '0;
    endcase
  end

endmodule

//--- design/exec_ctrl.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module exec_ctrl
  import mips_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_wb_cyc,
  input  logic               i_wb_stb,
  input  logic               i_wb_we,
  input  logic [`WB_AW-1:0]  i_wb_adr,
  input  logic [`DATA_W-1:0] i_wb_dat,
  output logic [`DATA_W-1:0] o_wb_dat,
  output logic               o_wb_ack,
  reg_port_if.ctrl           rp,
  output instr_u             o_instr,
  output alu_op_e            o_alu_op,
  input  logic [`DATA_W-1:0] i_result
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_EXEC = 2'd1;
  localparam logic [1:0] ST_ACK  = 2'd2;

  logic [1:0] state;
  instr_u     instr;
  logic       start;
  logic       is_instr;
  logic       is_reg;
  logic       r_type;
  logic       supported;

  assign start    = i_wb_cyc && i_wb_stb;
  assign is_instr = (i_wb_adr == `INSTR_ADDR);
  assign is_reg   = (i_wb_adr < `INSTR_ADDR);

  //////////////////////////////
  // Instruction decode
  //////////////////////////////

  assign r_type = (instr.rtype.op == '0);

  assign o_alu_op = r_type ? alu_op_e'(instr.rtype.funct) : alu_op_e'(instr.itype.op);
  assign o_instr  = instr;

  // A code must also belong to the format it came from
  always_comb
  begin
    case (o_alu_op)
      OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
      OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT:
        supported = r_type;
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI:
        supported = !r_type;
      default:
        supported = 1'b0;
    endcase
  end

  //////////////////////////////
  // Bus FSM
  //////////////////////////////

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      state <= ST_IDLE;
      instr <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (start && is_instr && i_wb_we)
          begin
            instr <= i_wb_dat;
            state <= ST_EXEC;
          end
          else if (start)
          begin
            state <= ST_ACK;
          end
        end
        // Result settles during this cycle
        ST_EXEC: state <= ST_ACK;
        default: state <= ST_IDLE;
      endcase
    end
  end

  // One cycle of ack per transfer
  assign o_wb_ack = (state == ST_ACK);

  // Read data captured on the first edge, held through ack
  always_ff @(posedge i_clk)
  begin
    if ((state == ST_IDLE) && start && !i_wb_we)
    begin
      if (is_instr)
      begin
        o_wb_dat <= instr;
      end
      else if (is_reg)
      begin
        o_wb_dat <= rp.rs_data;
      end
      else
      begin
        o_wb_dat <= '0;
      end
    end
  end

  //////////////////////////////
  // Register port
  //////////////////////////////

  always_comb
  begin
    rp.rs_addr = i_wb_adr[`REG_AW-1:0];
    rp.rt_addr = instr.rtype.rt;
    rp.we      = 1'b0;
    rp.wd_addr = i_wb_adr[`REG_AW-1:0];
    rp.wd_data = i_wb_dat;
    if (state == ST_IDLE)
    begin
      // Host write lands on the first edge
      rp.we = start && i_wb_we && is_reg;
    end
    else if (state == ST_EXEC)
    begin
      rp.rs_addr = instr.rtype.rs;
      // rd for R-type, rt for I-type
      rp.wd_addr = r_type ? instr.rtype.rd : instr.itype.rt;
      rp.wd_data = i_result;
      rp.we      = supported;
    end
  end

endmodule

//--- design/exec_top.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module exec_top
  import mips_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_wb_cyc,
  input  logic               i_wb_stb,
  input  logic               i_wb_we,
  input  logic [`WB_AW-1:0]  i_wb_adr,
  input  logic [`DATA_W-1:0] i_wb_dat,
  output logic [`DATA_W-1:0] o_wb_dat,
  output logic               o_wb_ack
);

  instr_u             instr;
  alu_op_e            alu_op;
  logic [`DATA_W-1:0] opa;
  logic [`DATA_W-1:0] opb;
  logic [4:0]         shamt;
  logic [`DATA_W-1:0] result;

  reg_port_if rp ();

  // Bus slave, decode and writeback
  exec_ctrl u_ctrl (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack),
    .rp       (rp),
    .o_instr  (instr),
    .o_alu_op (alu_op),
    .i_result (result)
  );

  reg_file u_regs (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .rp    (rp)
  );

  //////////////////////////////
  // Execute datapath
  //////////////////////////////

  operand_mux u_opmux (
    .i_instr   (instr),
    .i_alu_op  (alu_op),
    .i_rs_data (rp.rs_data),
    .i_rt_data (rp.rt_data),
    .o_opa     (opa),
    .o_opb     (opb),
    .o_shamt   (shamt)
  );

  mips_alu u_alu (
    .i_opa    (opa),
    .i_opb    (opb),
    .i_shamt  (shamt),
    .i_opcode (alu_op),
    .o_result (result)
  );

endmodule

//--- test/tb_exec_top.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module tb_exec_top;

  localparam string GOLDEN = "test/exec_golden.txt";
  localparam int    CYCLES_PER_LINE = 40;

  logic               i_clk;
  logic               i_rst;
  logic               i_wb_cyc;
  logic               i_wb_stb;
  logic               i_wb_we;
  logic [`WB_AW-1:0]  i_wb_adr;
  logic [`DATA_W-1:0] i_wb_dat;
  logic [`DATA_W-1:0] o_wb_dat;
  logic               o_wb_ack;

  longint watch_ns = 0;

  exec_top UUT (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_we  (i_wb_we),
    .i_wb_adr (i_wb_adr),
    .i_wb_dat (i_wb_dat),
    .o_wb_dat (o_wb_dat),
    .o_wb_ack (o_wb_ack)
  );

  // 20 ns period
  always #10 i_clk = ~i_clk;

  //////////////////////////////
  // Bus transfer
  //////////////////////////////

  // Drive on the falling edge, hold until ack is seen
  task automatic wb_transfer(input logic we, input logic [`WB_AW-1:0] adr,
                             input logic [`DATA_W-1:0] wdat,
                             output logic [`DATA_W-1:0] rdat);
    int n_wait;
    int exp_wait;

    // Instruction writes take an extra execute cycle
    exp_wait = (we && (adr == `INSTR_ADDR)) ? 2 : 1;
    n_wait   = 0;
    @(negedge i_clk);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    do
    begin
      @(negedge i_clk);
      n_wait++;
    end
    while (!o_wb_ack);
    assert (n_wait == exp_wait)
    else
    begin
      $display("mismatch at %0t ns: addr %0h ack after %0d cycles, expected %0d",
               $time, adr, n_wait, exp_wait);
      $display("sim failed");
      $fatal(1, "ack latency");
    end
    rdat     = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    // Ack lasts a single cycle
    @(negedge i_clk);
    assert (!o_wb_ack)
    else
    begin
      $display("mismatch at %0t ns: addr %0h ack held for more than one cycle",
               $time, adr);
      $display("sim failed");
      $fatal(1, "ack width");
    end
  endtask

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  initial
  begin
    wait (watch_ns != 0);
    #(watch_ns);
    $display("timeout: the DUT did not acknowledge a transfer in time");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////
  // Golden replay
  //////////////////////////////

  initial
  begin
    int                 fd;
    int                 n_lines;
    int                 code;
    logic [7:0]         kind;
    logic [`WB_AW-1:0]  adr;
    logic [`DATA_W-1:0] val;
    logic [`DATA_W-1:0] got;
    string              line;

    i_clk    = 1'b0;
    i_rst    = 1'b1;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = '0;
    i_wb_dat = '0;

    // First pass only sizes the watchdog
    n_lines = 0;
    fd = $fopen(GOLDEN, "r");
    if (fd == 0)
    begin
      $display("could not open the golden file %s", GOLDEN);
      $display("sim failed");
      $fatal(1, "missing golden file");
    end
    while ($fgets(line, fd) != 0)
    begin
      n_lines++;
    end
    $fclose(fd);
    watch_ns = longint'(n_lines * CYCLES_PER_LINE + 20) * 20;

    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;

    fd = $fopen(GOLDEN, "r");
    while (!$feof(fd))
    begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1)
      begin
        break;
      end
      if (kind == "#")
      begin
        code = $fgets(line, fd);
        continue;
      end
      code = $fscanf(fd, " %h %h", adr, val);
      if (kind == "W")
      begin
        wb_transfer(1'b1, adr, val, got);
      end
      else
      begin
        wb_transfer(1'b0, adr, '0, got);
        assert (got === val)
        else
        begin
          $display("mismatch at %0t ns: addr %0h expected %h got %h",
                   $time, adr, val, got);
          $display("sim failed");
          $fatal(1, "read check");
        end
      end
    end
    $fclose(fd);

    repeat (2) @(negedge i_clk);
    $display("sim passed");
    $finish;
  end

endmodule

//--- test/exec_golden.txt
# kind (W write, R read and check), word address in hex, data or expected value in hex
# address 20 is the instruction register
W 01 00000005
W 02 fffffff0
W 03 12345678
W 04 00000003
W 0f 00000024
W 18 00000077
W 19 00000077
W 00 deadbeef
R 00 00000000
R 01 00000005
R 02 fffffff0
R 03 12345678
W 20 00222821
R 05 fffffff5
W 20 00233023
R 06 edcba98d
W 20 00433824
R 07 12345670
W 20 00224025
R 08 fffffff5
W 20 00434826
R 09 edcba988
W 20 00235027
R 0a edcba982
W 20 00035900
R 0b 23456780
W 20 00026102
R 0c 0fffffff
W 20 00026903
R 0d ffffffff
W 20 00647004
R 0e 91a2b3c0
W 20 004f8006
R 10 0fffffff
W 20 004f8807
R 11 ffffffff
W 20 2032fff8
R 12 fffffffd
W 20 3053f0f0
R 13 0000f0f0
W 20 34348000
R 14 00008005
W 20 3855ffff
R 15 ffff000f
W 20 3c16abcd
R 16 abcd0000
W 20 0041b82a
R 17 00000001
W 20 0022c02a
R 18 00000000
W 20 2839ffff
R 19 00000000
W 20 8c250004
R 05 fffffff5
W 20 00430808
R 01 00000005
R 20 00430808

//--- files.f
+incdir+design
design/mips_pkg.sv
design/reg_port_if.sv
design/reg_file.sv
design/operand_mux.sv
design/mips_alu.sv
design/exec_ctrl.sv
design/exec_top.sv
test/tb_exec_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f files.f --top-module tb_exec_top -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "sim passed" &&
  echo "PASS" && exit 0 ||
  { echo "FAIL"; exit 1; }
